//--- Bender.yml
package:
  name: issue_core

sources:
  - logic/ooo_pkg.sv
  - logic/cdb_if.sv
  - logic/reg_status_file.sv
  - logic/reservation_station.sv
  - logic/int_alu_unit.sv
  - logic/mul_unit.sv
  - logic/issue_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_issue_core.sv

//--- all.f
+incdir+dv
logic/ooo_pkg.sv
logic/cdb_if.sv
logic/reg_status_file.sv
logic/reservation_station.sv
logic/int_alu_unit.sv
logic/mul_unit.sv
logic/issue_core_top.sv
dv/tb_issue_core.sv

//--- dv/issue_core_checks.svh
`ifndef ISSUE_CORE_CHECKS_SVH
`define ISSUE_CORE_CHECKS_SVH

// rv32i integer rules
function automatic xlen_t ref_alu(alu_op_e op, xlen_t a, xlen_t b);
    xlen_t r;
    int    sh;
    // only the low five bits of the shift amount count
    sh = int'(b[4:0]);
    r  = '0;
    case (op)
        alu_add:  r = a + b;
        alu_sub:  r = a + ~b + 32'd1;
        alu_and:  r = a & b;
        alu_or:   r = a | b;
        alu_xor:  r = a ^ b;
        alu_sll:  r = a << sh;
        alu_srl:  r = a >> sh;
        alu_sra: begin
            // logical shift, then refill the vacated top bits with the sign
            r = a >> sh;
            if (a[31]) begin
                r = r | ~(32'hffff_ffff >> sh);
            end
        end
        // differing signs decide on their own
        alu_slt:  r[0] = (a[31] != b[31]) ? a[31] : (a < b);
        alu_sltu: r[0] = (a < b);
        default:  r = 'x;
    endcase
    return r;
endfunction

// rv32m multiply rules, product taken modulo 2**64
function automatic xlen_t ref_mul(mul_op_e op, xlen_t a, xlen_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] p;
    wa = {32'b0, a};
    wb = {32'b0, b};
    // mul_h is signed times signed; mul_lo low half is the same either way
    if (op == mul_h) begin
        wa = {{32{a[31]}}, a};
        wb = {{32{b[31]}}, b};
    end
    p = wa * wb;
    return (op == mul_lo) ? p[31:0] : p[63:32];
endfunction

task automatic check_alu_result(input rob_idx_t rob, input reg_addr_t exp_rd,
                                input reg_addr_t got_rd, input xlen_t exp_data,
                                input xlen_t got_data);
    check_count++;
    if (got_rd !== exp_rd || got_data !== exp_data) begin
        error_count++;
        $display("CHECK FAILED @%0t: alu rob %0d expected rd %0d data %h, got rd %0d data %h",
                 $time, rob, exp_rd, exp_data, got_rd, got_data);
    end
endtask

task automatic check_mul_result(input rob_idx_t rob, input reg_addr_t exp_rd,
                                input reg_addr_t got_rd, input xlen_t exp_data,
                                input xlen_t got_data);
    check_count++;
    if (got_rd !== exp_rd || got_data !== exp_data) begin
        error_count++;
        $display("CHECK FAILED @%0t: mul rob %0d expected rd %0d data %h, got rd %0d data %h",
                 $time, rob, exp_rd, exp_data, got_rd, got_data);
    end
endtask

// cycles from the dispatch drive to the result sample
task automatic check_latency(input rob_idx_t rob, input int exp_lat, input int got_lat);
    check_count++;
    if (got_lat != exp_lat) begin
        error_count++;
        $display("CHECK FAILED @%0t: rob %0d latency expected %0d cycles, got %0d",
                 $time, rob, exp_lat, got_lat);
    end
endtask

task automatic check_level(input string what, input logic exp_level, input logic got_level);
    check_count++;
    if (got_level !== exp_level) begin
        error_count++;
        $display("CHECK FAILED @%0t: %s expected %b, got %b", $time, what, exp_level, got_level);
    end
endtask

`endif

//--- dv/tb_issue_core.sv
`timescale 1ns/100ps

module tb_issue_core;
    import ooo_pkg::*;

    localparam int          TIMEOUT_CYC = 200;
    localparam logic [31:0] SEED        = 32'ha81268a1;

    // one table row, expected value filled in program order
    typedef struct {
        int        test;
        op_type_e  op_type;
        alu_op_e   alu_op;
        mul_op_e   mul_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        logic      use_imm;
        logic      wait_idle;
        int        lat;
        xlen_t     exp;
    } stim_t;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    op_type_e  dispatch_op_type;
    alu_op_e   dispatch_alu_op;
    mul_op_e   dispatch_mul_op;
    reg_addr_t dispatch_rd;
    reg_addr_t dispatch_rs1;
    reg_addr_t dispatch_rs2;
    xlen_t     dispatch_imm;
    logic      dispatch_use_imm;
    rob_idx_t  dispatch_rob_idx;
    logic      alu_available;
    logic      mul_available;
    logic      alu_result_valid;
    rob_idx_t  alu_result_rob_idx;
    reg_addr_t alu_result_rd;
    xlen_t     alu_result_data;
    logic      mul_result_valid;
    rob_idx_t  mul_result_rob_idx;
    reg_addr_t mul_result_rd;
    xlen_t     mul_result_data;

    stim_t stim [$];
    string test_name [1:6] = '{"reset state", "alu ops", "mul corners",
                               "dependent chain", "station overlap", "same rd writers"};
    int error_count  = 0;
    int check_count  = 0;
    int tests_run    = 0;
    int cyc          = 0;
    int outstanding  = 0;
    int overlap_seen = 0;
    rob_idx_t next_rob = '0;

    // in-flight bookkeeping, indexed by rob
    logic      exp_pending [32];
    logic      exp_is_mul  [32];
    reg_addr_t exp_rd      [32];
    xlen_t     exp_data    [32];
    int        exp_lat     [32];
    int        exp_cyc     [32];

    `include "issue_core_checks.svh"

    issue_core_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic push_alu(input int test, input alu_op_e op, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2, input xlen_t imm,
                            input logic use_imm, input logic wait_idle, input int lat);
        stim_t e;
        e.test      = test;
        e.op_type   = alu;
        e.alu_op    = op;
        e.mul_op    = mul_lo;
        e.rd        = rd;
        e.rs1       = rs1;
        e.rs2       = rs2;
        e.imm       = imm;
        e.use_imm   = use_imm;
        e.wait_idle = wait_idle;
        e.lat       = lat;
        e.exp       = '0;
        stim.push_back(e);
    endtask

    task automatic push_mul(input int test, input mul_op_e op, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2,
                            input logic wait_idle, input int lat);
        stim_t e;
        e.test      = test;
        e.op_type   = mul;
        e.alu_op    = alu_add;
        e.mul_op    = op;
        e.rd        = rd;
        e.rs1       = rs1;
        e.rs2       = rs2;
        e.imm       = '0;
        e.use_imm   = 1'b0;
        e.wait_idle = wait_idle;
        e.lat       = lat;
        e.exp       = '0;
        stim.push_back(e);
    endtask

    task automatic build_stimulus();
        alu_op_e ops [10];
        ops = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
                alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu};
        // x1 and x2 seeded from x0, then every alu op on them
        push_alu(2, alu_add, 1, 0, 0, $urandom(), 1'b1, 1'b1, 2);
        push_alu(2, alu_add, 2, 0, 0, $urandom(), 1'b1, 1'b0, 2);
        for (int k = 0; k < 10; k++) begin
            push_alu(2, ops[k], reg_addr_t'(3 + k), 1, 2, '0, 1'b0, 1'b0, 2);
        end
        // corner operands for the multiplier
        push_alu(3, alu_add, 13, 0, 0, 32'h8000_0000, 1'b1, 1'b1, 2);
        push_alu(3, alu_add, 14, 0, 0, 32'hffff_ffff, 1'b1, 1'b0, 2);
        push_alu(3, alu_add, 15, 0, 0, 32'h7fff_ffff, 1'b1, 1'b0, 2);
        push_alu(3, alu_add, 16, 0, 0, $urandom(), 1'b1, 1'b0, 2);
        push_mul(3, mul_lo, 26, 13, 14, 1'b1, 4);
        push_mul(3, mul_h,  27, 13, 14, 1'b0, 4);
        push_mul(3, mul_hu, 28, 13, 14, 1'b0, 4);
        push_mul(3, mul_h,  29, 13, 13, 1'b0, 4);
        push_mul(3, mul_hu, 30, 14, 14, 1'b0, 4);
        push_mul(3, mul_h,  31, 15, 16, 1'b0, 4);
        push_mul(3, mul_lo, 10, 16, 15, 1'b0, 4);
        push_mul(3, mul_hu, 11, 16, 13, 1'b0, 4);
        // mul -> alu -> mul -> alu, each waiting on the previous tag
        push_mul(4, mul_lo,  17, 1, 2, 1'b1, 4);
        push_alu(4, alu_add, 18, 17, 1, '0, 1'b0, 1'b0, 0);
        push_mul(4, mul_h,   19, 18, 15, 1'b0, 0);
        push_alu(4, alu_sub, 20, 19, 17, '0, 1'b0, 1'b0, 0);
        // alu work finishes under a busy multiplier
        push_mul(5, mul_hu,  21, 16, 14, 1'b1, 4);
        push_alu(5, alu_xor, 22, 1, 0, $urandom(), 1'b1, 1'b0, 2);
        push_alu(5, alu_or,  23, 2, 0, $urandom(), 1'b1, 1'b0, 2);
        // second writer of x24 waits on the first; reader must see the second
        push_mul(6, mul_lo,  24, 16, 15, 1'b1, 4);
        push_alu(6, alu_add, 24, 24, 0, $urandom(), 1'b1, 1'b0, 0);
        push_mul(6, mul_lo,  25, 24, 1, 1'b0, 0);
    endtask

    // architectural state in program order
    task automatic fill_expected();
        xlen_t shadow [32];
        xlen_t a;
        xlen_t b;
        foreach (shadow[r]) begin
            shadow[r] = '0;
        end
        foreach (stim[i]) begin
            a = shadow[stim[i].rs1];
            b = stim[i].use_imm ? stim[i].imm : shadow[stim[i].rs2];
            if (stim[i].op_type == alu) begin
                stim[i].exp = ref_alu(stim[i].alu_op, a, b);
            end else begin
                stim[i].exp = ref_mul(stim[i].mul_op, a, b);
            end
            if (stim[i].rd != '0) begin
                shadow[stim[i].rd] = stim[i].exp;
            end
        end
    endtask

    task automatic abort_run(input string msg);
        $display("timeout: %s, gave up at %0t", msg, $time);
        $display("TEST FAIL");
        $finish;
    endtask

    // polled just after the rising edge
    task automatic wait_station(input op_type_e kind);
        int n;
        n = 0;
        while ((kind == alu) ? !alu_available : !mul_available) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYC) begin
                abort_run("reservation station never became available");
            end
        end
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (outstanding != 0 || !alu_available || !mul_available) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYC) begin
                abort_run("results still outstanding");
            end
        end
    endtask

    task automatic apply_entry(input int i);
        stim_t    e;
        rob_idx_t rob;
        e   = stim[i];
        rob = next_rob;
        if (e.wait_idle) begin
            drain_results();
        end
        wait_station(e.op_type);
        if (exp_pending[rob]) begin
            error_count++;
            $display("rob index %0d reused while its result is still in flight", rob);
        end
        dispatch_valid   = 1'b1;
        dispatch_op_type = e.op_type;
        dispatch_alu_op  = e.alu_op;
        dispatch_mul_op  = e.mul_op;
        dispatch_rd      = e.rd;
        dispatch_rs1     = e.rs1;
        dispatch_rs2     = e.rs2;
        dispatch_imm     = e.imm;
        dispatch_use_imm = e.use_imm;
        dispatch_rob_idx = rob;
        exp_pending[rob] = 1'b1;
        exp_is_mul[rob]  = (e.op_type == mul);
        exp_rd[rob]      = e.rd;
        exp_data[rob]    = e.exp;
        exp_lat[rob]     = e.lat;
        exp_cyc[rob]     = cyc;
        outstanding++;
        next_rob++;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        // captured, so the station must drop its available level
        if (e.op_type == alu) begin
            check_level("alu_available after dispatch", 1'b0, alu_available);
        end else begin
            check_level("mul_available after dispatch", 1'b0, mul_available);
        end
    endtask

    task automatic take_result(input logic is_mul, input rob_idx_t rob, input reg_addr_t rd,
                               input xlen_t data);
        if (!exp_pending[rob] || exp_is_mul[rob] != is_mul) begin
            error_count++;
            $display("unexpected %s result for rob %0d at %0t", is_mul ? "mul" : "alu",
                     rob, $time);
        end else begin
            if (is_mul) begin
                check_mul_result(rob, exp_rd[rob], rd, exp_data[rob], data);
            end else begin
                check_alu_result(rob, exp_rd[rob], rd, exp_data[rob], data);
            end
            if (exp_lat[rob] != 0) begin
                check_latency(rob, exp_lat[rob], cyc - exp_cyc[rob]);
            end
            exp_pending[rob] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic finish_test(input int t, input int err_start);
        drain_results();
        if (t == 5 && overlap_seen == 0) begin
            error_count++;
            $display("no alu result completed while the mul station was busy");
        end
        tests_run++;
        if (error_count == err_start) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t], error_count - err_start);
        end
    endtask

    // both lanes, sampled mid-cycle
    initial begin
        logic alu_free_due;
        logic mul_free_due;
        alu_free_due = 1'b0;
        mul_free_due = 1'b0;
        forever begin
            @(negedge clk);
            if (rst === 1'b0) begin
                // station freed at the edge closing its result cycle
                if (alu_free_due) begin
                    check_level("alu_available after own result", 1'b1, alu_available);
                end
                if (mul_free_due) begin
                    check_level("mul_available after own result", 1'b1, mul_available);
                end
                alu_free_due = 1'b0;
                mul_free_due = 1'b0;
                if (alu_result_valid === 1'b1) begin
                    if (mul_available === 1'b0) begin
                        overlap_seen++;
                    end
                    // entry still held while its result is on the lane
                    check_level("alu_available during own result", 1'b0, alu_available);
                    alu_free_due = 1'b1;
                    take_result(1'b0, alu_result_rob_idx, alu_result_rd, alu_result_data);
                end
                if (mul_result_valid === 1'b1) begin
                    check_level("mul_available during own result", 1'b0, mul_available);
                    mul_free_due = 1'b1;
                    take_result(1'b1, mul_result_rob_idx, mul_result_rd, mul_result_data);
                end
            end
        end
    end

    initial begin
        int err_start;
        int cur;
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_op_type = alu;
        dispatch_alu_op  = alu_add;
        dispatch_mul_op  = mul_lo;
        dispatch_rd      = '0;
        dispatch_rs1     = '0;
        dispatch_rs2     = '0;
        dispatch_imm     = '0;
        dispatch_use_imm = 1'b0;
        dispatch_rob_idx = '0;
        foreach (exp_pending[r]) begin
            exp_pending[r] = 1'b0;
        end
        void'($urandom(SEED));
        build_stimulus();
        fill_expected();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle after reset, nothing on the bus
        err_start = error_count;
        repeat (3) begin
            check_level("alu_available after reset", 1'b1, alu_available);
            check_level("mul_available after reset", 1'b1, mul_available);
            check_level("alu_result_valid after reset", 1'b0, alu_result_valid);
            check_level("mul_result_valid after reset", 1'b0, mul_result_valid);
            @(posedge clk);
            #1;
        end
        finish_test(1, err_start);
        cur          = stim[0].test;
        err_start    = error_count;
        overlap_seen = 0;
        foreach (stim[i]) begin
            if (stim[i].test != cur) begin
                finish_test(cur, err_start);
                cur          = stim[i].test;
                err_start    = error_count;
                overlap_seen = 0;
            end
            apply_entry(i);
        end
        finish_test(cur, err_start);
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- logic/cdb_if.sv
`timescale 1ns/100ps

interface cdb_if;
    import ooo_pkg::*;

    // alu lane
    logic      alu_valid;
    rob_idx_t  alu_rob_idx;
    reg_addr_t alu_rd;
    xlen_t     alu_data;

    // mul lane
    logic      mul_valid;
    rob_idx_t  mul_rob_idx;
    reg_addr_t mul_rd;
    xlen_t     mul_data;

    // each unit drives only its own lane
    modport producer (
        output alu_valid, alu_rob_idx, alu_rd, alu_data,
        output mul_valid, mul_rob_idx, mul_rd, mul_data
    );

    // stations and register file snoop both lanes
    modport listener (
        input alu_valid, alu_rob_idx, alu_rd, alu_data,
        input mul_valid, mul_rob_idx, mul_rd, mul_data
    );

endinterface

//--- logic/int_alu_unit.sv
`timescale 1ns/100ps

module int_alu_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  ooo_pkg::issue_t issue,
    cdb_if.producer         cdb
);
    import ooo_pkg::*;

    xlen_t      result;
    logic [4:0] shamt;

    // rv32i shifts only look at the low five bits
    assign shamt = issue.src2[4:0];

    always_comb begin
        case (issue.alu_op)
            alu_add:  result = issue.src1 + issue.src2;
            alu_sub:  result = issue.src1 - issue.src2;
            alu_and:  result = issue.src1 & issue.src2;
            alu_or:   result = issue.src1 | issue.src2;
            alu_xor:  result = issue.src1 ^ issue.src2;
            alu_sll:  result = issue.src1 << shamt;
            alu_srl:  result = issue.src1 >> shamt;
            alu_sra:  result = xlen_t'($signed(issue.src1) >>> shamt);
            // set-less-than, signed then unsigned
            alu_slt: begin
                result = {31'b0, $signed(issue.src1) < $signed(issue.src2)};
            end
            alu_sltu: begin
                result = {31'b0, issue.src1 < issue.src2};
            end
            default:  result = '0;
        endcase
    end

    // lane valid pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.alu_valid <= 1'b0;
        end else begin
            cdb.alu_valid <= issue_valid;
        end
    end

    // lane payload, held until the next issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb.alu_rob_idx <= issue.rob_idx;
            cdb.alu_rd      <= issue.rd;
            cdb.alu_data    <= result;
        end
    end

endmodule

//--- logic/issue_core_top.sv
`timescale 1ns/100ps

module issue_core_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  ooo_pkg::op_type_e   dispatch_op_type,
    input  ooo_pkg::alu_op_e    dispatch_alu_op,
    input  ooo_pkg::mul_op_e    dispatch_mul_op,
    input  ooo_pkg::reg_addr_t  dispatch_rd,
    input  ooo_pkg::reg_addr_t  dispatch_rs1,
    input  ooo_pkg::reg_addr_t  dispatch_rs2,
    input  ooo_pkg::xlen_t      dispatch_imm,
    input  logic                dispatch_use_imm,
    input  ooo_pkg::rob_idx_t   dispatch_rob_idx,
    output logic                alu_available,
    output logic                mul_available,
    output logic                alu_result_valid,
    output ooo_pkg::rob_idx_t   alu_result_rob_idx,
    output ooo_pkg::reg_addr_t  alu_result_rd,
    output ooo_pkg::xlen_t      alu_result_data,
    output logic                mul_result_valid,
    output ooo_pkg::rob_idx_t   mul_result_rob_idx,
    output ooo_pkg::reg_addr_t  mul_result_rd,
    output ooo_pkg::xlen_t      mul_result_data
);
    import ooo_pkg::*;

    dispatch_t dispatch;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      rs1_ready;
    logic      rs2_ready;
    rob_idx_t  rs1_tag;
    rob_idx_t  rs2_tag;
    logic      alu_issue_valid;
    logic      mul_issue_valid;
    issue_t    alu_issue;
    issue_t    mul_issue;

    cdb_if cdb ();

    // pack the dispatch port
    assign dispatch = '{
        valid:   dispatch_valid,
        op_type: dispatch_op_type,
        alu_op:  dispatch_alu_op,
        mul_op:  dispatch_mul_op,
        rd:      dispatch_rd,
        rs1:     dispatch_rs1,
        rs2:     dispatch_rs2,
        imm:     dispatch_imm,
        use_imm: dispatch_use_imm,
        rob_idx: dispatch_rob_idx
    };

    reg_status_file i_reg_status_file (
        .clk, .rst, .dispatch,
        .rs1_data, .rs1_ready, .rs1_tag,
        .rs2_data, .rs2_ready, .rs2_tag,
        .cdb (cdb.listener)
    );

    reservation_station #(.OP_KIND(alu)) i_alu_rs (
        .clk, .rst, .dispatch,
        .rs1_data, .rs1_ready, .rs1_tag,
        .rs2_data, .rs2_ready, .rs2_tag,
        .cdb         (cdb.listener),
        .available   (alu_available),
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue)
    );

    reservation_station #(.OP_KIND(mul)) i_mul_rs (
        .clk, .rst, .dispatch,
        .rs1_data, .rs1_ready, .rs1_tag,
        .rs2_data, .rs2_ready, .rs2_tag,
        .cdb         (cdb.listener),
        .available   (mul_available),
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue)
    );

    int_alu_unit i_int_alu_unit (
        .clk, .rst,
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue),
        .cdb         (cdb.producer)
    );

    mul_unit i_mul_unit (
        .clk, .rst,
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue),
        .cdb         (cdb.producer)
    );

    // bus lanes out to the result ports
    assign alu_result_valid   = cdb.alu_valid;
    assign alu_result_rob_idx = cdb.alu_rob_idx;
    assign alu_result_rd      = cdb.alu_rd;
    assign alu_result_data    = cdb.alu_data;
    assign mul_result_valid   = cdb.mul_valid;
    assign mul_result_rob_idx = cdb.mul_rob_idx;
    assign mul_result_rd      = cdb.mul_rd;
    assign mul_result_data    = cdb.mul_data;

endmodule

//--- logic/mul_unit.sv
`timescale 1ns/100ps

module mul_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  ooo_pkg::issue_t issue,
    cdb_if.producer         cdb
);
    import ooo_pkg::*;

    // stage 1, extended operands
    logic               s1_valid;
    logic signed [32:0] s1_a;
    logic signed [32:0] s1_b;
    mul_op_e            s1_op;
    reg_addr_t          s1_rd;
    rob_idx_t           s1_rob_idx;

    // stage 2, full product
    logic               s2_valid;
    logic signed [63:0] s2_prod;
    mul_op_e            s2_op;
    reg_addr_t          s2_rd;
    rob_idx_t           s2_rob_idx;

    logic ext_signed;

    // only mul_hu treats its operands as unsigned
    assign ext_signed = (issue.mul_op != mul_hu);

    // valid bits down the pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            cdb.mul_valid <= 1'b0;
        end else begin
            s1_valid      <= issue_valid;
            s2_valid      <= s1_valid;
            cdb.mul_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        // extend to 33 bits, sign or zero per op
        s1_a       <= {ext_signed & issue.src1[31], issue.src1};
        s1_b       <= {ext_signed & issue.src2[31], issue.src2};
        s1_op      <= issue.mul_op;
        s1_rd      <= issue.rd;
        s1_rob_idx <= issue.rob_idx;

        // low 64 bits of the 66-bit product are exact
        s2_prod    <= s1_a * s1_b;
        s2_op      <= s1_op;
        s2_rd      <= s1_rd;
        s2_rob_idx <= s1_rob_idx;

        // pick the half onto the mul lane
        cdb.mul_data    <= (s2_op == mul_lo) ? s2_prod[31:0] : s2_prod[63:32];
        cdb.mul_rd      <= s2_rd;
        cdb.mul_rob_idx <= s2_rob_idx;
    end

endmodule

//--- logic/ooo_pkg.sv
package ooo_pkg;

    // datapath and tag widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_IDX_W  = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // producer tag, taken from the rob index of the writing instruction
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;

    // which execution unit an instruction needs
    typedef enum logic {
        alu,
        mul
    } op_type_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_e;

    // low product, signed high, unsigned high
    typedef enum logic [1:0] {
        mul_lo,
        mul_h,
        mul_hu
    } mul_op_e;

    typedef enum logic [1:0] {
        rs_idle,
        rs_waiting,
        rs_issued
    } rs_status_e;

    // one instruction offered on the dispatch port
    typedef struct packed {
        logic      valid;
        op_type_e  op_type;
        alu_op_e   alu_op;
        mul_op_e   mul_op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     imm;
        logic      use_imm;
        rob_idx_t  rob_idx;
    } dispatch_t;

    // station to unit, operands already resolved
    typedef struct packed {
        alu_op_e   alu_op;
        mul_op_e   mul_op;
        reg_addr_t rd;
        rob_idx_t  rob_idx;
        xlen_t     src1;
        xlen_t     src2;
    } issue_t;

endpackage

//--- logic/reg_status_file.sv
`timescale 1ns/100ps

module reg_status_file (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    output ooo_pkg::xlen_t     rs1_data,
    output logic               rs1_ready,
    output ooo_pkg::rob_idx_t  rs1_tag,
    output ooo_pkg::xlen_t     rs2_data,
    output logic               rs2_ready,
    output ooo_pkg::rob_idx_t  rs2_tag,
    cdb_if.listener            cdb
);
    import ooo_pkg::*;

    // architectural values, busy bits and producer tags
    xlen_t    regs     [32];
    rob_idx_t prod_tag [32];
    logic [31:0] busy;

    // both read ports handled in one loop
    reg_addr_t src_addr [2];
    xlen_t     src_val  [2];
    logic      src_rdy  [2];
    rob_idx_t  src_tag  [2];

    assign src_addr[0] = dispatch.rs1;
    assign src_addr[1] = dispatch.rs2;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_tag[i] = prod_tag[src_addr[i]];
            src_val[i] = regs[src_addr[i]];
            // x0 and clean registers are ready straight away
            src_rdy[i] = (src_addr[i] == '0) || !busy[src_addr[i]];
            if (src_addr[i] != '0 && busy[src_addr[i]]) begin
                // producer broadcasting right now, bypass its data
                if (cdb.alu_valid && cdb.alu_rob_idx == src_tag[i]) begin
                    src_val[i] = cdb.alu_data;
                    src_rdy[i] = 1'b1;
                end else if (cdb.mul_valid && cdb.mul_rob_idx == src_tag[i]) begin
                    src_val[i] = cdb.mul_data;
                    src_rdy[i] = 1'b1;
                end
            end
        end
    end

    assign rs1_data  = src_val[0];
    assign rs1_ready = src_rdy[0];
    assign rs1_tag   = src_tag[0];
    assign rs2_data  = src_val[1];
    assign rs2_ready = src_rdy[1];
    assign rs2_tag   = src_tag[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int r = 0; r < 32; r++) begin
                regs[r]     <= '0;
                prod_tag[r] <= '0;
            end
        end else begin
            // alu lane first so mul wins on the same rd
            if (cdb.alu_valid && cdb.alu_rd != '0) begin
                regs[cdb.alu_rd] <= cdb.alu_data;
                // only the latest producer may clear busy
                if (cdb.alu_rob_idx == prod_tag[cdb.alu_rd]) begin
                    busy[cdb.alu_rd] <= 1'b0;
                end
            end
            if (cdb.mul_valid && cdb.mul_rd != '0) begin
                regs[cdb.mul_rd] <= cdb.mul_data;
                if (cdb.mul_rob_idx == prod_tag[cdb.mul_rd]) begin
                    busy[cdb.mul_rd] <= 1'b0;
                end
            end
            // new producer overrides any clear in the same cycle
            if (dispatch.valid && dispatch.rd != '0) begin
                busy[dispatch.rd]     <= 1'b1;
                prod_tag[dispatch.rd] <= dispatch.rob_idx;
            end
        end
    end

    // x0 is hardwired, no dispatch may mark it pending
    a_x0_never_busy: assert property (
        @(posedge clk) disable iff (rst)
        dispatch.valid && dispatch.rd == '0 |=> !busy[0]
    );

endmodule

//--- logic/reservation_station.sv
`timescale 1ns/100ps

module reservation_station #(
    parameter ooo_pkg::op_type_e OP_KIND = ooo_pkg::alu
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    input  ooo_pkg::xlen_t     rs1_data,
    input  logic               rs1_ready,
    input  ooo_pkg::rob_idx_t  rs1_tag,
    input  ooo_pkg::xlen_t     rs2_data,
    input  logic               rs2_ready,
    input  ooo_pkg::rob_idx_t  rs2_tag,
    cdb_if.listener            cdb,
    output logic               available,
    output logic               issue_valid,
    output ooo_pkg::issue_t    issue
);
    import ooo_pkg::*;

    rs_status_e state;

    // entry payload
    alu_op_e   ent_alu_op;
    mul_op_e   ent_mul_op;
    reg_addr_t ent_rd;
    rob_idx_t  ent_rob_idx;
    xlen_t     src1;
    xlen_t     src2;
    rob_idx_t  src1_tag;
    rob_idx_t  src2_tag;
    logic      src1_rdy;
    logic      src2_rdy;

    logic capture;
    logic own_done;

    // instruction for this unit type
    assign capture = dispatch.valid && dispatch.op_type == OP_KIND;

    // own lane only, a tag on the other lane belongs to someone else
    assign own_done = (OP_KIND == alu) ?
                      (cdb.alu_valid && cdb.alu_rob_idx == ent_rob_idx) :
                      (cdb.mul_valid && cdb.mul_rob_idx == ent_rob_idx);

    assign available   = (state == rs_idle);
    assign issue_valid = (state == rs_waiting) && src1_rdy && src2_rdy;

    assign issue.alu_op  = ent_alu_op;
    assign issue.mul_op  = ent_mul_op;
    assign issue.rd      = ent_rd;
    assign issue.rob_idx = ent_rob_idx;
    assign issue.src1    = src1;
    assign issue.src2    = src2;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rs_idle;
        end else begin
            case (state)
                rs_idle: begin
                    if (capture) begin
                        state <= rs_waiting;
                    end
                end
                rs_waiting: begin
                    if (issue_valid) begin
                        state <= rs_issued;
                    end
                end
                rs_issued: begin
                    // free once our result is on the bus
                    if (own_done) begin
                        state <= rs_idle;
                    end
                end
                default: begin
                    state <= rs_idle;
                end
            endcase
        end
    end

    // capture and wake-up
    always_ff @(posedge clk) begin
        if (state == rs_idle && capture) begin
            ent_alu_op  <= dispatch.alu_op;
            ent_mul_op  <= dispatch.mul_op;
            ent_rd      <= dispatch.rd;
            ent_rob_idx <= dispatch.rob_idx;
            src1        <= rs1_data;
            src1_rdy    <= rs1_ready;
            src1_tag    <= rs1_tag;
            // immediate replaces rs2 and never waits
            if (dispatch.use_imm) begin
                src2     <= dispatch.imm;
                src2_rdy <= 1'b1;
            end else begin
                src2     <= rs2_data;
                src2_rdy <= rs2_ready;
            end
            src2_tag    <= rs2_tag;
        end else if (state == rs_waiting) begin
            // either lane can wake either operand
            if (!src1_rdy) begin
                if (cdb.alu_valid && cdb.alu_rob_idx == src1_tag) begin
                    src1     <= cdb.alu_data;
                    src1_rdy <= 1'b1;
                end else if (cdb.mul_valid && cdb.mul_rob_idx == src1_tag) begin
                    src1     <= cdb.mul_data;
                    src1_rdy <= 1'b1;
                end
            end
            if (!src2_rdy) begin
                if (cdb.alu_valid && cdb.alu_rob_idx == src2_tag) begin
                    src2     <= cdb.alu_data;
                    src2_rdy <= 1'b1;
                end else if (cdb.mul_valid && cdb.mul_rob_idx == src2_tag) begin
                    src2     <= cdb.mul_data;
                    src2_rdy <= 1'b1;
                end
            end
        end
    end

    // dispatch must respect the available level
    a_no_capture_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        capture |-> state == rs_idle
    );

    // one issue pulse per entry, then wait for the result
    a_issue_from_waiting: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> state == rs_waiting ##1 (state == rs_issued && !issue_valid)
    );

endmodule
